// File: hdl/bru_pkg.sv
package bru_pkg;

  //////////////////////////////////////////////////
  // Widths and reset values
  //////////////////////////////////////////////////

  // Data and PC width
  localparam int unsigned XLEN = 32;

  // First fetch address once reset is released
  localparam logic [XLEN-1:0] PC_INIT = 32'h200;

  // Global history length in resolved branches
  localparam int unsigned BP_GLOBAL_BITS = 2;

  // Counter table holds 2**BHT_IDX_BITS entries
  localparam int unsigned BHT_IDX_BITS = 6;
  localparam int unsigned BHT_DEPTH    = 1 << BHT_IDX_BITS;

  // Compressed instructions present, so 2-byte targets are legal
  localparam bit HAS_RVC = 1'b1;

  // Saturating counter encodings, bit 1 set means taken
  localparam logic [1:0] CNT_WEAK_NT = 2'b01;
  localparam logic [1:0] CNT_MIN     = 2'b00;
  localparam logic [1:0] CNT_MAX     = 2'b11;

  //////////////////////////////////////////////////
  // Opcodes and funct3 values
  //////////////////////////////////////////////////

  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;

  localparam opcode_t OPC_BRANCH  = 7'b1100011;
  localparam opcode_t OPC_JAL     = 7'b1101111;
  localparam opcode_t OPC_JALR    = 7'b1100111;
  localparam opcode_t OPC_MISCMEM = 7'b0001111;

  // Conditional branch conditions
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // FENCE.I with all register and immediate fields zero
  localparam logic [31:0] FENCE_I_WORD = 32'h0000_100F;

  //////////////////////////////////////////////////
  // Instruction and exception types
  //////////////////////////////////////////////////

  // Raw instruction word as delivered by decode
  typedef logic [31:0] instr_t;

  // R-type field split, opcode and funct3 sit in the same place for SB
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    funct3_t    funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } insn_fields_t;

  // Branch and jump offsets, bit 0 always zero
  typedef logic [12:0] imm_sb_t;
  typedef logic [20:0] imm_uj_t;

  // Exception bits that travel with an instruction
  typedef struct packed {
    logic misaligned_instruction;
    logic illegal_instruction;
    logic any;
  } exc_t;

endpackage

// File: hdl/bp_train_if.sv
`timescale 1ns/1ns

interface bp_train_if;
  import bru_pkg::*;

  // Single-cycle strobe, one training step per high cycle
  logic                      update;
  // Resolved direction of the branch being trained
  logic                      btaken;
  // PC of that branch, re-forms the table index
  logic [XLEN-1:0]           pc;
  // History that was used at lookup time
  logic [BP_GLOBAL_BITS-1:0] history;
  // History that later lookups index with, this branch shifted in
  logic [BP_GLOBAL_BITS-1:0] index_history;

  // Branch unit side
  modport src (output update, btaken, pc, history, index_history);

  // Predictor side
  modport dst (input update, btaken, pc, history, index_history);

endinterface

// File: hdl/gshare_predictor.sv
`timescale 1ns/1ns

module gshare_predictor (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic [bru_pkg::XLEN-1:0]           lookup_pc_i,
  output logic [1:0]                         predict_o,
  output logic [bru_pkg::BP_GLOBAL_BITS-1:0] history_o,
  bp_train_if.dst                            train
);
  import bru_pkg::*;

  typedef logic [BHT_IDX_BITS-1:0] bht_idx_t;

  //////////////////////////////////////////////////
  // State
  //////////////////////////////////////////////////

  // 2-bit saturating counters
  logic [1:0]                cnt_q [BHT_DEPTH];
  // Global history, newest outcome in bit 0
  logic [BP_GLOBAL_BITS-1:0] ghr_q;

  bht_idx_t   rd_idx;
  bht_idx_t   wr_idx;
  logic [1:0] cnt_cur;
  logic [1:0] cnt_next;

  // Word-address bits of the PC xor'd with zero-extended history
  function automatic bht_idx_t form_index(input logic [XLEN-1:0]           pc,
                                          input logic [BP_GLOBAL_BITS-1:0] hist);
    form_index = pc[BHT_IDX_BITS+1:2] ^ bht_idx_t'(hist);
  endfunction

  //////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////

  assign rd_idx    = form_index(lookup_pc_i, ghr_q);
  assign predict_o = cnt_q[rd_idx];
  // Branch unit records this and hands it back for training
  assign history_o = ghr_q;

  //////////////////////////////////////////////////
  // Training
  //////////////////////////////////////////////////

  // Same index the branch saw when it was looked up
  assign wr_idx  = form_index(train.pc, train.history);
  assign cnt_cur = cnt_q[wr_idx];

  // Count towards the outcome, stop at either end
  always_comb begin
    cnt_next = cnt_cur;
    if (train.btaken) begin
      if (cnt_cur != CNT_MAX) begin
        cnt_next = cnt_cur + 2'd1;
      end
    end else begin
      if (cnt_cur != CNT_MIN) begin
        cnt_next = cnt_cur - 2'd1;
      end
    end
  end

  // All entries start weakly not taken
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < BHT_DEPTH; i++) begin
        cnt_q[i] <= CNT_WEAK_NT;
      end
    end else if (train.update) begin
      cnt_q[wr_idx] <= cnt_next;
    end
  end

  // Shift in the outcome once per trained branch
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ghr_q <= '0;
    end else if (train.update) begin
      ghr_q <= {ghr_q[BP_GLOBAL_BITS-2:0], train.btaken};
    end
  end

  // Strobe must be a clean level or the table takes garbage
  a_update_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(train.update)
  );

endmodule

// File: hdl/branch_unit.sv
`timescale 1ns/1ns

module branch_unit (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               stall_i,
  input  logic                               st_flush_i,
  input  logic                               later_exc_i,
  input  logic [bru_pkg::XLEN-1:0]           id_pc_i,
  input  bru_pkg::instr_t                    id_insn_i,
  input  logic                               id_bubble_i,
  input  bru_pkg::exc_t                      id_exc_i,
  input  logic [bru_pkg::XLEN-1:0]           opa_i,
  input  logic [bru_pkg::XLEN-1:0]           opb_i,
  input  logic [1:0]                         id_predict_i,
  input  logic [bru_pkg::BP_GLOBAL_BITS-1:0] id_history_i,
  output logic [bru_pkg::XLEN-1:0]           nxt_pc_o,
  output logic                               flush_o,
  output logic                               cacheflush_o,
  output logic                               btaken_o,
  output bru_pkg::exc_t                      exc_o,
  bp_train_if.src                            train
);
  import bru_pkg::*;

  //////////////////////////////////////////////////
  // Declarations
  //////////////////////////////////////////////////

  insn_fields_t fields;
  logic         is_16bit;

  imm_sb_t         imm_sb;
  imm_uj_t         imm_uj;
  logic [XLEN-1:0] ext_imm_sb;
  logic [XLEN-1:0] ext_imm_uj;

  logic [XLEN-1:0] seq_pc;
  logic [XLEN-1:0] jalr_sum;
  logic [XLEN-1:0] nxt_pc;

  // Resolution results for the instruction in decode
  logic cond_true;
  logic btaken;
  logic bp_update;
  logic pipeflush;
  logic cacheflush;
  logic chk_target;
  logic target_bad;
  logic misaligned;

  // Outcomes of resolved branches, kept in step with the predictor
  logic [BP_GLOBAL_BITS-1:0] hist_q;

  // Training record
  logic                      update_q;
  logic [XLEN-1:0]           train_pc_q;
  logic [BP_GLOBAL_BITS-1:0] train_hist_q;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  assign fields = id_insn_i;

  // Low bits not both set mark a 16-bit encoding
  assign is_16bit = ~&id_insn_i[1:0];
  assign seq_pc   = id_pc_i + (is_16bit ? XLEN'(2) : XLEN'(4));

  // SB offset, scattered across the upper bits
  assign imm_sb = {id_insn_i[31], id_insn_i[7], id_insn_i[30:25], id_insn_i[11:8], 1'b0};
  // UJ offset
  assign imm_uj = {id_insn_i[31], id_insn_i[19:12], id_insn_i[20], id_insn_i[30:21], 1'b0};

  assign ext_imm_sb = {{(XLEN-$bits(imm_sb)){imm_sb[$bits(imm_sb)-1]}}, imm_sb};
  assign ext_imm_uj = {{(XLEN-$bits(imm_uj)){imm_uj[$bits(imm_uj)-1]}}, imm_uj};

  assign jalr_sum = opa_i + opb_i;

  // Branch condition from funct3
  always_comb begin
    case (fields.funct3)
      F3_BEQ:  cond_true = (opa_i == opb_i);
      F3_BNE:  cond_true = (opa_i != opb_i);
      F3_BLT:  cond_true = ($signed(opa_i) <  $signed(opb_i));
      F3_BGE:  cond_true = ($signed(opa_i) >= $signed(opb_i));
      F3_BLTU: cond_true = (opa_i <  opb_i);
      F3_BGEU: cond_true = (opa_i >= opb_i);
      default: cond_true = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Resolve
  //////////////////////////////////////////////////

  always_comb begin
    btaken     = 1'b0;
    bp_update  = 1'b0;
    pipeflush  = 1'b0;
    cacheflush = 1'b0;
    chk_target = 1'b0;
    nxt_pc     = seq_pc;
    // Bubbles fall through with no side effects
    if (!id_bubble_i) begin
      case (fields.opcode)
        OPC_JAL: begin
          btaken     = 1'b1;
          // Front end already redirected when it predicted taken
          pipeflush  = ~id_predict_i[1];
          chk_target = 1'b1;
          nxt_pc     = id_pc_i + ext_imm_uj;
        end
        OPC_JALR: begin
          // Register target is never predicted
          btaken     = 1'b1;
          pipeflush  = 1'b1;
          chk_target = 1'b1;
          nxt_pc     = {jalr_sum[XLEN-1:1], 1'b0};
        end
        OPC_BRANCH: begin
          btaken     = cond_true;
          // A stalled branch has not resolved yet
          bp_update  = ~stall_i;
          pipeflush  = cond_true ^ id_predict_i[1];
          chk_target = 1'b1;
          if (cond_true) begin
            nxt_pc = id_pc_i + ext_imm_sb;
          end
        end
        OPC_MISCMEM: begin
          // Only FENCE.I restarts fetch, plain FENCE passes
          if (id_insn_i == FENCE_I_WORD) begin
            pipeflush  = 1'b1;
            cacheflush = 1'b1;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // Halfword alignment is enough with compressed support
  assign target_bad = (HAS_RVC != 1'b0) ? nxt_pc[0] : |nxt_pc[1:0];
  assign misaligned = id_exc_i.misaligned_instruction | (chk_target & target_bad);

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  // Reset flushes so fetch restarts at PC_INIT
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_o      <= 1'b1;
      cacheflush_o <= 1'b0;
      btaken_o     <= 1'b0;
      update_q     <= 1'b0;
    end else begin
      flush_o      <= pipeflush;
      cacheflush_o <= cacheflush;
      btaken_o     <= btaken;
      update_q     <= bp_update;
    end
  end

  always_ff @(posedge clk_i) begin
    train_pc_q   <= id_pc_i;
    train_hist_q <= id_history_i;
  end

  // History advances as soon as the branch resolves
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hist_q <= '0;
    end else if (bp_update) begin
      hist_q <= {hist_q[BP_GLOBAL_BITS-2:0], btaken};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nxt_pc_o <= PC_INIT;
    end else if (!stall_i) begin
      nxt_pc_o <= nxt_pc;
    end
  end

  // Squashed instructions carry no exceptions
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exc_o <= '0;
    end else if (!stall_i) begin
      if (flush_o || st_flush_i || later_exc_i) begin
        exc_o <= '0;
      end else begin
        exc_o.misaligned_instruction <= misaligned;
        exc_o.illegal_instruction    <= id_exc_i.illegal_instruction;
        exc_o.any                    <= id_exc_i.any | misaligned;
      end
    end
  end

  // Training record towards the predictor
  assign train.update        = update_q;
  assign train.btaken        = btaken_o;
  assign train.pc            = train_pc_q;
  assign train.history       = train_hist_q;
  assign train.index_history = hist_q;

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_cacheflush_flush: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cacheflush_o |-> flush_o
  );

  // JALR target lands even on the next cycle
  a_jalr_even: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (!id_bubble_i && !stall_i && fields.opcode == OPC_JALR) |=> !nxt_pc_o[0]
  );

endmodule

// File: hdl/branch_top.sv
`timescale 1ns/1ns

module branch_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     stall_i,
  input  logic                     st_flush_i,
  input  logic                     later_exc_i,
  input  logic [bru_pkg::XLEN-1:0] id_pc_i,
  input  bru_pkg::instr_t          id_insn_i,
  input  logic                     id_bubble_i,
  input  logic                     id_misaligned_i,
  input  logic                     id_illegal_i,
  input  logic [bru_pkg::XLEN-1:0] opa_i,
  input  logic [bru_pkg::XLEN-1:0] opb_i,
  output logic [bru_pkg::XLEN-1:0] nxt_pc_o,
  output logic                     flush_o,
  output logic                     cacheflush_o,
  output logic                     btaken_o,
  output logic                     exc_misaligned_o,
  output logic                     exc_illegal_o,
  output logic                     exc_any_o
);
  import bru_pkg::*;

  logic [1:0]                predict;
  logic [BP_GLOBAL_BITS-1:0] history;
  exc_t                      id_exc;
  exc_t                      exc;

  // Resolved branches back to the predictor
  bp_train_if bp_train ();

  //////////////////////////////////////////////////
  // Exception packing
  //////////////////////////////////////////////////

  assign id_exc.misaligned_instruction = id_misaligned_i;
  assign id_exc.illegal_instruction    = id_illegal_i;
  assign id_exc.any                    = id_misaligned_i | id_illegal_i;

  assign exc_misaligned_o = exc.misaligned_instruction;
  assign exc_illegal_o    = exc.illegal_instruction;
  assign exc_any_o        = exc.any;

  // Lookup on the decode PC
  gshare_predictor i_gshare_predictor (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .lookup_pc_i (id_pc_i),
    .predict_o   (predict),
    .history_o   (history),
    .train       (bp_train.dst)
  );

  branch_unit i_branch_unit (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .stall_i      (stall_i),
    .st_flush_i   (st_flush_i),
    .later_exc_i  (later_exc_i),
    .id_pc_i      (id_pc_i),
    .id_insn_i    (id_insn_i),
    .id_bubble_i  (id_bubble_i),
    .id_exc_i     (id_exc),
    .opa_i        (opa_i),
    .opb_i        (opb_i),
    .id_predict_i (predict),
    .id_history_i (history),
    .nxt_pc_o     (nxt_pc_o),
    .flush_o      (flush_o),
    .cacheflush_o (cacheflush_o),
    .btaken_o     (btaken_o),
    .exc_o        (exc),
    .train        (bp_train.src)
  );

endmodule

// File: bench/tb_branch_model.svh
`ifndef TB_BRANCH_MODEL_SVH
`define TB_BRANCH_MODEL_SVH

// LFSR state, then the model copy of the counter table and history
logic [31:0]               lfsr_state;
logic [1:0]                mdl_cnt [BHT_DEPTH];
logic [BP_GLOBAL_BITS-1:0] mdl_ghr;

//////////////////////////////////////////////////
// Random source
//////////////////////////////////////////////////

// Galois LFSR, one step for each bit handed out
function automatic logic [31:0] rand_bits(input int unsigned n);
  logic [31:0] r;
  r = '0;
  for (int unsigned i = 0; i < n; i++) begin
    r = {r[30:0], lfsr_state[0]};
    if (lfsr_state[0]) begin
      lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
    end else begin
      lfsr_state = lfsr_state >> 1;
    end
  end
  return r;
endfunction

//////////////////////////////////////////////////
// Decode and resolve
//////////////////////////////////////////////////

// Conditional branch offset, sign extended
function automatic logic [31:0] sb_offset(input logic [31:0] insn);
  return {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
endfunction

// JAL offset, sign extended
function automatic logic [31:0] uj_offset(input logic [31:0] insn);
  return {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
endfunction

function automatic logic branch_cond(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
  case (f3)
    F3_BEQ:  return a == b;
    F3_BNE:  return a != b;
    F3_BLT:  return $signed(a) < $signed(b);
    F3_BGE:  return $signed(a) >= $signed(b);
    F3_BLTU: return a < b;
    F3_BGEU: return a >= b;
    default: return 1'b0;
  endcase
endfunction

function automatic logic [31:0] next_pc(input logic [31:0] pc, input logic [31:0] insn,
                                        input logic [31:0] a, input logic [31:0] b,
                                        input logic taken, input logic bubble);
  logic [31:0] seq;
  logic [31:0] sum;
  // Low bits 11 mark a full 32-bit instruction
  seq = (insn[1:0] == 2'b11) ? pc + 32'd4 : pc + 32'd2;
  sum = a + b;
  if (bubble) begin
    return seq;
  end
  case (insn[6:0])
    OPC_JAL:    return pc + uj_offset(insn);
    OPC_JALR:   return {sum[31:1], 1'b0};
    OPC_BRANCH: return taken ? pc + sb_offset(insn) : seq;
    default:    return seq;
  endcase
endfunction

//////////////////////////////////////////////////
// Predictor copy
//////////////////////////////////////////////////

// Word address bits xor history
function automatic logic [BHT_IDX_BITS-1:0] bht_index(input logic [31:0] pc,
                                                      input logic [BP_GLOBAL_BITS-1:0] hist);
  return pc[BHT_IDX_BITS+1:2] ^ {{(BHT_IDX_BITS-BP_GLOBAL_BITS){1'b0}}, hist};
endfunction

function automatic void model_reset();
  for (int i = 0; i < BHT_DEPTH; i++) begin
    mdl_cnt[i] = 2'b01;
  end
  mdl_ghr = '0;
endfunction

// Saturating count towards the outcome, then shift it into the history
function automatic void model_train(input logic [31:0] pc,
                                    input logic [BP_GLOBAL_BITS-1:0] hist, input logic taken);
  logic [BHT_IDX_BITS-1:0] idx;
  idx = bht_index(pc, hist);
  if (taken && mdl_cnt[idx] != 2'b11) begin
    mdl_cnt[idx] = mdl_cnt[idx] + 2'd1;
  end else if (!taken && mdl_cnt[idx] != 2'b00) begin
    mdl_cnt[idx] = mdl_cnt[idx] - 2'd1;
  end
  mdl_ghr = {mdl_ghr[BP_GLOBAL_BITS-2:0], taken};
endfunction

`endif

// File: bench/tb_branch_top.sv
`timescale 1ns/1ns

module tb_branch_top;
  import bru_pkg::*;

  `include "tb_branch_model.svh"

  localparam logic [31:0] NOP_WORD   = 32'h0000_0013;
  localparam logic [31:0] C_NOP_WORD = 32'h0000_0001;
  localparam logic [31:0] FENCE_WORD = 32'h0ff0_000f;
  localparam logic [31:0] JALR_WORD  = {12'h000, 5'd1, 3'b000, 5'd1, OPC_JALR};

  logic        clk_i;
  logic        rst_ni;
  logic        stall_i;
  logic        st_flush_i;
  logic        later_exc_i;
  logic [31:0] id_pc_i;
  logic [31:0] id_insn_i;
  logic        id_bubble_i;
  logic        id_misaligned_i;
  logic        id_illegal_i;
  logic [31:0] opa_i;
  logic [31:0] opb_i;
  logic [31:0] nxt_pc_o;
  logic        flush_o;
  logic        cacheflush_o;
  logic        btaken_o;
  logic        exc_misaligned_o;
  logic        exc_illegal_o;
  logic        exc_any_o;

  // Expected outputs for the inputs taken at the last rising edge
  logic [31:0] exp_pc;
  logic        exp_flush;
  logic        exp_cflush;
  logic        exp_taken;
  logic        exp_mis;
  logic        exp_ill;
  logic        exp_any;
  // Branch that trains the model table on the next edge
  logic                      pend_upd;
  logic                      pend_taken;
  logic [31:0]               pend_pc;
  logic [BP_GLOBAL_BITS-1:0] pend_hist;

  int unsigned err_cnt;
  int unsigned test_base;
  int unsigned test_cnt;
  int unsigned fail_cnt;

  logic [31:0] r;
  logic [31:0] a;
  logic [31:0] b;

  branch_top i_branch_top (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .stall_i          (stall_i),
    .st_flush_i       (st_flush_i),
    .later_exc_i      (later_exc_i),
    .id_pc_i          (id_pc_i),
    .id_insn_i        (id_insn_i),
    .id_bubble_i      (id_bubble_i),
    .id_misaligned_i  (id_misaligned_i),
    .id_illegal_i     (id_illegal_i),
    .opa_i            (opa_i),
    .opb_i            (opb_i),
    .nxt_pc_o         (nxt_pc_o),
    .flush_o          (flush_o),
    .cacheflush_o     (cacheflush_o),
    .btaken_o         (btaken_o),
    .exc_misaligned_o (exc_misaligned_o),
    .exc_illegal_o    (exc_illegal_o),
    .exc_any_o        (exc_any_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Watchdog for the whole run
  initial begin
    #50000;
    $display("timeout: the test sequence did not reach its end");
    $display("Simulation failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Reference model, stepped on every rising edge
  //////////////////////////////////////////////////

  task automatic step_model();
    logic [BP_GLOBAL_BITS-1:0] hist;
    logic [1:0]  pred;
    logic [6:0]  opc;
    logic        is_br;
    logic        is_jal;
    logic        is_jalr;
    logic        is_fi;
    logic        taken;
    logic        mis;
    logic        clear;
    logic [31:0] target;
    hist    = mdl_ghr;
    pred    = mdl_cnt[bht_index(id_pc_i, hist)];
    opc     = id_insn_i[6:0];
    is_br   = !id_bubble_i && opc == OPC_BRANCH;
    is_jal  = !id_bubble_i && opc == OPC_JAL;
    is_jalr = !id_bubble_i && opc == OPC_JALR;
    is_fi   = !id_bubble_i && id_insn_i == FENCE_I_WORD;
    taken   = is_jal || is_jalr || (is_br && branch_cond(id_insn_i[14:12], opa_i, opb_i));
    target  = next_pc(id_pc_i, id_insn_i, opa_i, opb_i, taken, id_bubble_i);
    mis     = id_misaligned_i || ((is_br || is_jal || is_jalr) && target[0]);
    // Last cycle's branch lands in the table on this same edge
    if (pend_upd) begin
      model_train(pend_pc, pend_hist, pend_taken);
    end
    // Stalled branch has not resolved
    pend_upd   = is_br && !stall_i;
    pend_taken = taken;
    pend_pc    = id_pc_i;
    pend_hist  = hist;
    // Squash behind the previous flush or a later stage
    clear = exp_flush || st_flush_i || later_exc_i;
    if (!stall_i) begin
      exp_pc  = target;
      exp_mis = mis && !clear;
      exp_ill = id_illegal_i && !clear;
      exp_any = (mis || id_illegal_i) && !clear;
    end
    exp_flush  = is_jalr || is_fi || (is_jal && !pred[1]) || (is_br && (taken != pred[1]));
    exp_cflush = is_fi;
    exp_taken  = taken;
  endtask

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      model_reset();
      pend_upd   = 1'b0;
      exp_pc     = PC_INIT;
      exp_flush  = 1'b1;
      exp_cflush = 1'b0;
      exp_taken  = 1'b0;
      exp_mis    = 1'b0;
      exp_ill    = 1'b0;
      exp_any    = 1'b0;
    end else begin
      step_model();
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("error: %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    err_cnt++;
  endtask

  // Outputs are settled by the falling edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (nxt_pc_o !== exp_pc) begin
        report_mismatch("nxt_pc_o", nxt_pc_o, exp_pc);
      end
      if (flush_o !== exp_flush) begin
        report_mismatch("flush_o", flush_o, exp_flush);
      end
      if (cacheflush_o !== exp_cflush) begin
        report_mismatch("cacheflush_o", cacheflush_o, exp_cflush);
      end
      if (btaken_o !== exp_taken) begin
        report_mismatch("btaken_o", btaken_o, exp_taken);
      end
      if (exc_misaligned_o !== exp_mis) begin
        report_mismatch("exc_misaligned_o", exc_misaligned_o, exp_mis);
      end
      if (exc_illegal_o !== exp_ill) begin
        report_mismatch("exc_illegal_o", exc_illegal_o, exp_ill);
      end
      if (exc_any_o !== exp_any) begin
        report_mismatch("exc_any_o", exc_any_o, exp_any);
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // ctl is {bubble, stall, misaligned, illegal, st_flush, later_exc}
  task automatic issue(input logic [31:0] pc, input logic [31:0] insn, input logic [31:0] opa,
                       input logic [31:0] opb, input logic [5:0] ctl);
    @(posedge clk_i);
    id_pc_i         <= pc;
    id_insn_i       <= insn;
    opa_i           <= opa;
    opb_i           <= opb;
    id_bubble_i     <= ctl[5];
    stall_i         <= ctl[4];
    id_misaligned_i <= ctl[3];
    id_illegal_i    <= ctl[2];
    st_flush_i      <= ctl[1];
    later_exc_i     <= ctl[0];
  endtask

  task automatic idle();
    issue(PC_INIT, NOP_WORD, 32'd0, 32'd0, 6'b100000);
  endtask

  // Random conditional branch, funct3 010 and 011 folded onto BLT and BGE
  function automatic logic [31:0] rand_branch();
    logic [31:0] v;
    logic [2:0]  f3;
    v  = rand_bits(15);
    f3 = v[14:12];
    if (f3[2:1] == 2'b01) begin
      f3 = f3 ^ 3'b110;
    end
    return {v[11], v[9:4], 5'd2, 5'd1, f3, v[3:0], v[10], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] rand_jal();
    logic [31:0] v;
    v = rand_bits(20);
    return {v[19], v[9:0], v[10], v[18:11], 5'd1, OPC_JAL};
  endfunction

  // Mixed slot, stall and exception inputs only when asked for
  task automatic random_cycle(input bit with_stall, input bit with_exc);
    logic [31:0] v;
    logic [31:0] pc;
    logic [31:0] insn;
    logic [31:0] opa;
    logic [31:0] opb;
    v   = rand_bits(6);
    pc  = PC_INIT + {v[5:0], 1'b0};
    opa = rand_bits(32);
    opb = rand_bits(32);
    v   = rand_bits(3);
    case (v[2:0])
      3'd0, 3'd1: insn = rand_branch();
      3'd2:       insn = rand_jal();
      3'd3:       insn = JALR_WORD;
      3'd4:       insn = FENCE_I_WORD;
      3'd5:       insn = C_NOP_WORD;
      default:    insn = NOP_WORD;
    endcase
    v = rand_bits(8);
    issue(pc, insn, opa, opb, {&v[1:0], with_stall & v[2], with_exc & v[3] & v[4],
                               with_exc & v[5], with_exc & v[6] & v[7], with_exc & v[6] & ~v[7]});
  endtask

  task automatic wait_flush_clear(input int unsigned limit);
    int unsigned n;
    n = 0;
    while (flush_o !== 1'b0 && n < limit) begin
      @(negedge clk_i);
      n++;
    end
    if (flush_o !== 1'b0) begin
      $display("flush_o still high %0d cycles after reset was released", limit);
      err_cnt++;
    end
  endtask

  // Drain the last slot through the compare, then report the test
  task automatic finish_test(input string name);
    idle();
    idle();
    @(negedge clk_i);
    test_cnt++;
    if (err_cnt != test_base) begin
      fail_cnt++;
    end
    $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_base);
    test_base = err_cnt;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    lfsr_state      = 32'd45;
    err_cnt         = 0;
    test_base       = 0;
    test_cnt        = 0;
    fail_cnt        = 0;
    rst_ni          = 1'b0;
    stall_i         = 1'b0;
    st_flush_i      = 1'b0;
    later_exc_i     = 1'b0;
    id_pc_i         = PC_INIT;
    id_insn_i       = NOP_WORD;
    id_bubble_i     = 1'b1;
    id_misaligned_i = 1'b0;
    id_illegal_i    = 1'b0;
    opa_i           = '0;
    opb_i           = '0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    // 1: reset values, then the reset flush drops
    @(negedge clk_i);
    if (nxt_pc_o !== PC_INIT || flush_o !== 1'b1 || cacheflush_o !== 1'b0 ||
        btaken_o !== 1'b0 || exc_any_o !== 1'b0 || exc_illegal_o !== 1'b0) begin
      $display("error: %0t ns: outputs after reset are not the reset values", $time);
      err_cnt++;
    end
    wait_flush_clear(8);
    finish_test("reset");

    // 2: branches on a small PC set so counters and history get reused
    for (int i = 0; i < 300; i++) begin
      r = rand_bits(8);
      a = rand_bits(32);
      b = rand_bits(32);
      if (r[1:0] == 2'b00) begin
        b = a;
      end
      issue(PC_INIT + {r[6:2], 2'b00}, rand_branch(), a, b, 6'b000000);
      if (r[7]) begin
        idle();
      end
    end
    finish_test("conditional branches");

    // 3: jumps, incoming misaligned flag on about half
    for (int i = 0; i < 80; i++) begin
      r = rand_bits(8);
      a = rand_bits(32);
      b = rand_bits(32);
      issue(PC_INIT + {r[7:3], 1'b0}, r[0] ? rand_jal() : JALR_WORD, a, b, {2'b00, r[1], 3'b000});
      // Bubble slot lets the next jump load its exception bits
      if (r[2]) begin
        idle();
      end
    end
    // Bubble slot first, so no jump flush clears the exception register
    idle();
    // Operand sum 1003 gives target 1002, halfword aligned
    issue(PC_INIT, JALR_WORD, 32'h1001, 32'h2, 6'b000000);
    idle();
    @(negedge clk_i);
    if (nxt_pc_o !== 32'h1002 || exc_misaligned_o !== 1'b0) begin
      $display("error: %0t ns: JALR target %0h misaligned %b", $time, nxt_pc_o, exc_misaligned_o);
      err_cnt++;
    end
    finish_test("jal and jalr");

    // 4: FENCE.I against a plain FENCE
    issue(PC_INIT, FENCE_I_WORD, 32'd0, 32'd0, 6'b000000);
    issue(PC_INIT, FENCE_WORD, 32'd0, 32'd0, 6'b000000);
    @(negedge clk_i);
    if (flush_o !== 1'b1 || cacheflush_o !== 1'b1) begin
      $display("error: %0t ns: flush_o and cacheflush_o low after FENCE.I", $time);
      err_cnt++;
    end
    idle();
    @(negedge clk_i);
    if (flush_o !== 1'b0 || cacheflush_o !== 1'b0) begin
      $display("error: %0t ns: flush_o or cacheflush_o high after FENCE", $time);
      err_cnt++;
    end
    finish_test("fence");

    // 5: illegal flag passes, then clears under st_flush_i
    issue(PC_INIT, NOP_WORD, 32'd0, 32'd0, 6'b000100);
    issue(PC_INIT, NOP_WORD, 32'd0, 32'd0, 6'b000110);
    @(negedge clk_i);
    if (exc_illegal_o !== 1'b1) begin
      $display("error: %0t ns: exc_illegal_o low one cycle after id_illegal_i", $time);
      err_cnt++;
    end
    for (int i = 0; i < 150; i++) begin
      random_cycle(1'b0, 1'b1);
    end
    finish_test("exceptions");

    // 6: held PC under stall, bubble on a taken BEQ
    issue(PC_INIT, NOP_WORD, 32'd0, 32'd0, 6'b000000);
    issue(32'h300, NOP_WORD, 32'd0, 32'd0, 6'b010000);
    issue(PC_INIT, {1'b0, 6'd1, 5'd2, 5'd1, F3_BEQ, 4'd0, 1'b0, OPC_BRANCH}, 32'd5, 32'd5,
          6'b100000);
    @(negedge clk_i);
    // NOP before the stall still sets the PC
    if (nxt_pc_o !== PC_INIT + 32'd4) begin
      $display("error: %0t ns: nxt_pc_o moved while stall_i was high", $time);
      err_cnt++;
    end
    idle();
    @(negedge clk_i);
    if (nxt_pc_o !== PC_INIT + 32'd4 || flush_o !== 1'b0) begin
      $display("error: %0t ns: bubble gave nxt_pc_o %0h flush_o %b", $time, nxt_pc_o, flush_o);
      err_cnt++;
    end
    for (int i = 0; i < 200; i++) begin
      random_cycle(1'b1, 1'b1);
    end
    finish_test("stall and bubble");

    $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+bench
hdl/bru_pkg.sv
hdl/bp_train_if.sv
hdl/gshare_predictor.sv
hdl/branch_unit.sv
hdl/branch_top.sv
bench/tb_branch_top.sv
